/* logic/conv_pkg.sv */
`default_nettype none

package conv_pkg;

	localparam int PIX_W        = 8;                      // One pixel or one weight
	localparam int KERNEL_DIM   = 3;                      // Kernel side
	localparam int KERNEL_TAPS  = KERNEL_DIM * KERNEL_DIM; // Weights per kernel
	localparam int WBEAT_W      = 64;                     // One weight beat
	localparam int KERNEL_BEATS = 2;                      // Beats per kernel load

	// Command level on i_ctrl, code 3 is ignored
	typedef enum logic [1:0] {
		END   = 2'd0, // Stop for good
		START = 2'd1, // Begin computing
		HOLD  = 2'd2  // Pause, kernel load starts over
	} ctrl_op_t;

	typedef enum logic [2:0] {
		FINISH  = 3'd1, // Terminal
		WAIT    = 3'd2, // Idle after reset or HOLD
		COMPUTE = 3'd3  // Results valid
	} seq_state_t;

endpackage

`default_nettype wire

/* logic/row_window.sv */
`timescale 1ns/1ps
`default_nettype none

module row_window import conv_pkg::*; #(
	parameter int PIXELS = 8
) (
	input  wire                      clk,
	input  wire                      rst,
	input  wire [PIXELS*PIX_W-1:0]   i_row,       // Pixel p in byte p
	input  wire                      i_row_valid, // Real row this cycle
	input  wire                      i_pad_row,   // Left padding, zero row
	output logic [PIXELS*PIX_W-1:0]  o_row_old,   // Window row 0
	output logic [PIXELS*PIX_W-1:0]  o_row_mid,   // Window row 1
	output logic [PIXELS*PIX_W-1:0]  o_row_new    // Window row 2
);

	logic shift_en; // Any row event
	logic [PIXELS*PIX_W-1:0] row_in;

	assign shift_en = i_row_valid | i_pad_row;
	assign row_in   = i_row_valid ? i_row : '0; // Real row wins over padding

	// Three-deep row shift register
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_row_old <= '0;
			o_row_mid <= '0;
			o_row_new <= '0;
		end else if (shift_en) begin
			o_row_old <= o_row_mid;  // Oldest row drops out
			o_row_mid <= o_row_new;
			o_row_new <= row_in;     // Newest row or zeros
		end
	end

endmodule

`default_nettype wire

/* logic/kernel_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module kernel_bank import conv_pkg::*; (
	input  wire                          clk,
	input  wire                          rst,
	input  wire [WBEAT_W-1:0]            i_wbeat,          // One weight beat
	input  wire                          i_wbeat_valid,
	input  wire                          i_kernel_restart, // Level, beat count back to 0
	output logic [KERNEL_TAPS*PIX_W-1:0] o_kernel          // Weight j in byte j
);

	localparam int KERNEL_W = KERNEL_TAPS * PIX_W;
	localparam int TAIL_W   = KERNEL_W - WBEAT_W;           // Part of beat 1 kept
	localparam int CNT_W    = $clog2(KERNEL_BEATS + 1);
	localparam logic [CNT_W-1:0] BEATS_FULL = CNT_W'(KERNEL_BEATS);

	logic [CNT_W-1:0] beat_cnt; // Saturates at BEATS_FULL
	logic             beat_take;

	assign beat_take = i_wbeat_valid && (beat_cnt < BEATS_FULL); // Extra beats dropped

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			beat_cnt <= '0;
			o_kernel <= '0;
		end else begin
			if (beat_take) begin
				if (beat_cnt == '0)
					o_kernel[WBEAT_W-1:0] <= i_wbeat;               // Weights 0..7
				else
					o_kernel[KERNEL_W-1:WBEAT_W] <= i_wbeat[TAIL_W-1:0]; // Weight 8 only
				beat_cnt <= beat_cnt + 1'b1;
			end
			// Restart keeps the weights, the next beat overwrites from byte 0
			if (i_kernel_restart)
				beat_cnt <= '0;
		end
	end

endmodule

`default_nettype wire

/* logic/conv_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_sequencer import conv_pkg::*; (
	input  wire       clk,
	input  wire       rst,
	input  ctrl_op_t  i_ctrl,           // Opcode level
	output logic      o_computing,      // High in COMPUTE
	output logic      o_kernel_restart, // High while HOLD is applied
	output logic      o_finish          // High in FINISH
);

	seq_state_t state;
	seq_state_t state_nxt;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			state <= WAIT;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state; // Hold by default
		case (state)
			WAIT: begin
				if (i_ctrl == START)
					state_nxt = COMPUTE;
				else if (i_ctrl == END)
					state_nxt = FINISH;
			end
			COMPUTE: begin
				if (i_ctrl == HOLD)
					state_nxt = WAIT;    // Pause, valid drops two edges later
				else if (i_ctrl == END)
					state_nxt = FINISH;
			end
			FINISH: state_nxt = FINISH; // No way out but reset
			default: state_nxt = WAIT;  // Unused code recovers
		endcase
	end

	assign o_computing      = (state == COMPUTE);
	assign o_finish         = (state == FINISH);
	assign o_kernel_restart = (i_ctrl == HOLD); // Any state, as a reload request

endmodule

`default_nettype wire

/* logic/mult_cube.sv */
`timescale 1ns/1ps
`default_nettype none

module mult_cube import conv_pkg::*; (
	input  wire                          clk,
	input  wire                          rst,
	input  wire [KERNEL_TAPS*PIX_W-1:0]  i_window,  // Lane j in byte j
	input  wire [KERNEL_TAPS*PIX_W-1:0]  i_kernel,  // Weight j in byte j
	output logic [KERNEL_TAPS*PIX_W-1:0] o_products // Low byte of each lane product
);

	localparam int WIN_W = KERNEL_TAPS * PIX_W;

	logic [WIN_W-1:0] window_q; // Stage 1
	logic [WIN_W-1:0] kernel_q;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			window_q <= '0;
			kernel_q <= '0;
		end else begin
			window_q <= i_window;
			kernel_q <= i_kernel;
		end
	end

	// Stage 2, nine lane multipliers
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_products <= '0;
		end else begin
			for (int j = 0; j < KERNEL_TAPS; j++) begin
				o_products[j*PIX_W +: PIX_W] <=
					PIX_W'(window_q[j*PIX_W +: PIX_W] * kernel_q[j*PIX_W +: PIX_W]); // Truncated
			end
		end
	end

endmodule

`default_nettype wire

/* logic/cube_array.sv */
`timescale 1ns/1ps
`default_nettype none

module cube_array import conv_pkg::*; #(
	parameter int PIXELS = 8
) (
	input  wire                                 clk,
	input  wire                                 rst,
	input  wire [PIXELS*PIX_W-1:0]              i_row_old,   // Window row 0
	input  wire [PIXELS*PIX_W-1:0]              i_row_mid,   // Window row 1
	input  wire [PIXELS*PIX_W-1:0]              i_row_new,   // Window row 2
	input  wire [KERNEL_TAPS*PIX_W-1:0]         i_kernel,
	input  wire                                 i_computing, // From sequencer
	output logic [PIXELS*KERNEL_TAPS*PIX_W-1:0] o_products,  // Cube k in slice k
	output logic                                o_res_valid
);

	localparam int ROW_W = PIXELS * PIX_W;
	localparam int WIN_W = KERNEL_TAPS * PIX_W;

	logic [ROW_W-1:0] rows [KERNEL_DIM]; // Index 0 is oldest
	logic             computing_q;       // Matches cube stage 1

	assign rows[0] = i_row_old;
	assign rows[1] = i_row_mid;
	assign rows[2] = i_row_new;

	for (genvar k = 0; k < PIXELS; k++) begin : g_cube
		logic [WIN_W-1:0] window;

		// Columns k, k+1, k+2 with wrap at the right edge
		always_comb begin
			for (int r = 0; r < KERNEL_DIM; r++) begin
				for (int c = 0; c < KERNEL_DIM; c++) begin
					window[(r*KERNEL_DIM+c)*PIX_W +: PIX_W] =
						rows[r][((k+c)%PIXELS)*PIX_W +: PIX_W];
				end
			end
		end

		mult_cube u_cube (
			.clk        (clk),
			.rst        (rst),
			.i_window   (window),
			.i_kernel   (i_kernel),
			.o_products (o_products[k*WIN_W +: WIN_W])
		);
	end

	// Two-stage valid, same depth as the cubes
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			computing_q <= 1'b0;
			o_res_valid <= 1'b0;
		end else begin
			computing_q <= i_computing;
			o_res_valid <= computing_q;
		end
	end

endmodule

`default_nettype wire

/* logic/conv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_core import conv_pkg::*; #(
	parameter int PIXELS = 8
) (
	input  wire                                 clk,
	input  wire                                 rst,
	input  ctrl_op_t                            i_ctrl,        // Opcode level
	input  wire [PIXELS*PIX_W-1:0]              i_row,         // Eight pixels
	input  wire                                 i_row_valid,
	input  wire                                 i_pad_row,     // Zero row strobe
	input  wire [WBEAT_W-1:0]                   i_wbeat,
	input  wire                                 i_wbeat_valid,
	output logic [PIXELS*KERNEL_TAPS*PIX_W-1:0] o_products,
	output logic                                o_res_valid,
	output logic                                o_finish
);

	logic [PIXELS*PIX_W-1:0]      row_old;
	logic [PIXELS*PIX_W-1:0]      row_mid;
	logic [PIXELS*PIX_W-1:0]      row_new;
	logic [KERNEL_TAPS*PIX_W-1:0] kernel;
	logic                         computing;
	logic                         kernel_restart;

	// Producer
	row_window #(
		.PIXELS (PIXELS)
	) u_row_window (
		.clk         (clk),
		.rst         (rst),
		.i_row       (i_row),
		.i_row_valid (i_row_valid),
		.i_pad_row   (i_pad_row),
		.o_row_old   (row_old),
		.o_row_mid   (row_mid),
		.o_row_new   (row_new)
	);

	// Buffer
	kernel_bank u_kernel_bank (
		.clk              (clk),
		.rst              (rst),
		.i_wbeat          (i_wbeat),
		.i_wbeat_valid    (i_wbeat_valid),
		.i_kernel_restart (kernel_restart),
		.o_kernel         (kernel)
	);

	conv_sequencer u_sequencer (
		.clk              (clk),
		.rst              (rst),
		.i_ctrl           (i_ctrl),
		.o_computing      (computing),
		.o_kernel_restart (kernel_restart),
		.o_finish         (o_finish)
	);

	// Consumer
	cube_array #(
		.PIXELS (PIXELS)
	) u_cube_array (
		.clk         (clk),
		.rst         (rst),
		.i_row_old   (row_old),
		.i_row_mid   (row_mid),
		.i_row_new   (row_new),
		.i_kernel    (kernel),
		.i_computing (computing),
		.o_products  (o_products),
		.o_res_valid (o_res_valid)
	);

endmodule

`default_nettype wire

/* tests/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
	parameter int HALF_PERIOD = 5 // ns, 10 ns period
) (
	output logic o_clk
);

	initial o_clk = 1'b0;

	always #HALF_PERIOD o_clk = ~o_clk; // Free running

endmodule

`default_nettype wire

/* tests/conv_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_checker (
	input wire clk,
	input wire rst,
	input wire i_res_valid, // Core result valid
	input wire i_finish     // Core terminal flag
);

	int unsigned fail_cnt; // Failed assertions so far

	initial fail_cnt = 0;

	// FINISH is terminal
	property finish_sticky;
		@(posedge clk) disable iff (!rst) i_finish |=> i_finish;
	endproperty

	// Last valid result leaves the pipe two edges after FINISH
	property valid_off_after_finish;
		@(posedge clk) disable iff (!rst) i_finish |-> ##2 !i_res_valid;
	endproperty

	property flags_known;
		@(posedge clk) disable iff (!rst) !$isunknown({i_res_valid, i_finish});
	endproperty

	a_finish_sticky: assert property (finish_sticky) else begin
		$error("o_finish fell after it had risen");
		fail_cnt++;
	end

	a_valid_off: assert property (valid_off_after_finish) else begin
		$error("o_res_valid still high in the third cycle after o_finish rose");
		fail_cnt++;
	end

	a_flags_known: assert property (flags_known) else begin
		$error("o_res_valid or o_finish is unknown after reset");
		fail_cnt++;
	end

endmodule

`default_nettype wire

/* tests/conv_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_tb import conv_pkg::*; ();

	localparam int PIXELS     = 8;
	localparam int ROW_W      = PIXELS * PIX_W;
	localparam int CUBE_W     = KERNEL_TAPS * PIX_W;
	localparam int WAIT_LIMIT = 50;               // Cycles per wait
	localparam ctrl_op_t NOP  = ctrl_op_t'(2'd3); // Unused code means no command

	logic                       clk;
	logic                       rst;
	ctrl_op_t                   i_ctrl;
	logic [ROW_W-1:0]           i_row;
	logic                       i_row_valid;
	logic                       i_pad_row;
	logic [WBEAT_W-1:0]         i_wbeat;
	logic                       i_wbeat_valid;
	logic [PIXELS*CUBE_W-1:0]   o_products;
	logic                       o_res_valid;
	logic                       o_finish;
	string                      test_name;

	logic [ROW_W-1:0] m_row [KERNEL_DIM];  // Model window with index 0 oldest
	logic [PIX_W-1:0] m_w [KERNEL_TAPS];   // Model kernel weights
	int               m_cnt;               // Model beat count
	logic             m_computing;
	logic             m_finished;
	logic [ROW_W-1:0] h1_row [KERNEL_DIM]; // One edge back
	logic [ROW_W-1:0] h2_row [KERNEL_DIM]; // Two edges back as seen on o_products
	logic [PIX_W-1:0] h1_w [KERNEL_TAPS];
	logic [PIX_W-1:0] h2_w [KERNEL_TAPS];
	logic             v1;
	logic             v2;                  // Expected o_res_valid

	clk_gen #(.HALF_PERIOD(5)) u_clk_gen (.o_clk(clk));

	conv_core #(.PIXELS(PIXELS)) UUT (
		.clk           (clk),
		.rst           (rst),
		.i_ctrl        (i_ctrl),
		.i_row         (i_row),
		.i_row_valid   (i_row_valid),
		.i_pad_row     (i_pad_row),
		.i_wbeat       (i_wbeat),
		.i_wbeat_valid (i_wbeat_valid),
		.o_products    (o_products),
		.o_res_valid   (o_res_valid),
		.o_finish      (o_finish)
	);

	bind conv_core conv_checker u_checker (
		.clk         (clk),
		.rst         (rst),
		.i_res_valid (o_res_valid),
		.i_finish    (o_finish)
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	// Reference model on the same edge as the DUT
	always @(posedge clk) begin
		if (!rst) begin
			m_row       <= '{default: '0};
			h1_row      <= '{default: '0};
			h2_row      <= '{default: '0};
			m_w         <= '{default: '0};
			h1_w        <= '{default: '0};
			h2_w        <= '{default: '0};
			m_cnt       <= 0;
			m_computing <= 1'b0;
			m_finished  <= 1'b0;
			v1          <= 1'b0;
			v2          <= 1'b0;
		end else begin
			if (i_row_valid || i_pad_row) begin
				m_row[0] <= m_row[1];
				m_row[1] <= m_row[2];
				m_row[2] <= i_row_valid ? i_row : '0; // Padding inserts zeros
			end
			if (i_wbeat_valid && m_cnt < KERNEL_BEATS) begin
				if (m_cnt == 0) begin
					for (int b = 0; b < WBEAT_W / PIX_W; b++)
						m_w[b] <= i_wbeat[b*PIX_W +: PIX_W];
				end else begin
					m_w[KERNEL_TAPS-1] <= i_wbeat[PIX_W-1:0]; // Byte 0 only
				end
				m_cnt <= m_cnt + 1;
			end
			if (i_ctrl == HOLD)
				m_cnt <= 0; // Restart wins over the increment
			if (!m_finished) begin
				if (i_ctrl == END) begin
					m_finished  <= 1'b1;
					m_computing <= 1'b0;
				end else if (!m_computing && i_ctrl == START) begin
					m_computing <= 1'b1;
				end else if (m_computing && i_ctrl == HOLD) begin
					m_computing <= 1'b0;
				end
			end
			h1_row <= m_row;
			h2_row <= h1_row;
			h1_w   <= m_w;
			h2_w   <= h1_w;
			v1     <= m_computing;
			v2     <= v1;
		end
	end

	// Lane j is row j/3, column j%3, pixel (k + column) mod PIXELS
	function automatic logic [PIX_W-1:0] lane_expect(input int k, input int j);
		logic [2*PIX_W-1:0] full;
		int                 pix;
		pix  = (k + j % KERNEL_DIM) % PIXELS;
		full = h2_row[j / KERNEL_DIM][pix*PIX_W +: PIX_W] * h2_w[j];
		return full[PIX_W-1:0]; // Low byte only
	endfunction

	task automatic check_products();
		logic [PIX_W-1:0] exp_b;
		logic [PIX_W-1:0] act_b;
		for (int k = 0; k < PIXELS; k++) begin
			for (int j = 0; j < KERNEL_TAPS; j++) begin
				exp_b = lane_expect(k, j);
				act_b = o_products[k*CUBE_W + j*PIX_W +: PIX_W];
				assert (act_b === exp_b) else
					abort_run($sformatf("Error %s: cube %0d lane %0d expected %h, actual %h",
						test_name, k, j, exp_b, act_b));
			end
		end
	endtask

	// Direct lane check against the current model window
	task automatic check_lane(input int k, input int j, input int pix, input int r);
		logic [2*PIX_W-1:0] full;
		logic [PIX_W-1:0]   act;
		full = m_row[r][pix*PIX_W +: PIX_W] * m_w[j];
		act  = o_products[k*CUBE_W + j*PIX_W +: PIX_W];
		assert (act === full[PIX_W-1:0]) else
			abort_run($sformatf("Error %s: cube %0d lane %0d expected %h, actual %h",
				test_name, k, j, full[PIX_W-1:0], act));
	endtask

	// Outputs settle by the falling edge
	always @(negedge clk) begin
		if (rst) begin
			if (UUT.u_checker.fail_cnt != 0)
				abort_run("A bound protocol assertion on the core outputs failed");
			assert (o_res_valid === v2) else
				abort_run($sformatf("Error %s: o_res_valid expected %0b, actual %0b",
					test_name, v2, o_res_valid));
			assert (o_finish === m_finished) else
				abort_run($sformatf("Error %s: o_finish expected %0b, actual %0b",
					test_name, m_finished, o_finish));
			if (o_res_valid)
				check_products();
		end
	end

	function automatic logic [ROW_W-1:0] rand_row();
		return {$urandom, $urandom};
	endfunction

	function automatic logic [ROW_W-1:0] distinct_row(input int r);
		logic [ROW_W-1:0] row;
		for (int p = 0; p < PIXELS; p++)
			row[p*PIX_W +: PIX_W] = PIX_W'(32 * r + p + 1); // No repeats in a row
		return row;
	endfunction

	task automatic command(input ctrl_op_t op);
		@(posedge clk);
		i_ctrl        <= op;
		i_row_valid   <= 1'b0;
		i_pad_row     <= 1'b0;
		i_wbeat_valid <= 1'b0;
	endtask

	task automatic push_row(input logic [ROW_W-1:0] row, input logic pad);
		@(posedge clk);
		i_row         <= row;
		i_row_valid   <= 1'b1;
		i_pad_row     <= pad; // Both together count as a row
		i_wbeat_valid <= 1'b0;
	endtask

	task automatic pad_only();
		@(posedge clk);
		i_row_valid   <= 1'b0;
		i_pad_row     <= 1'b1;
		i_wbeat_valid <= 1'b0;
	endtask

	task automatic send_beat(input logic [WBEAT_W-1:0] beat);
		@(posedge clk);
		i_wbeat       <= beat;
		i_wbeat_valid <= 1'b1;
		i_row_valid   <= 1'b0;
		i_pad_row     <= 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			i_row_valid   <= 1'b0;
			i_pad_row     <= 1'b0;
			i_wbeat_valid <= 1'b0;
		end
	endtask

	task automatic wait_valid(input logic level);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (o_res_valid !== level && n < WAIT_LIMIT);
		if (o_res_valid !== level)
			abort_run($sformatf("o_res_valid did not reach %0b within %0d cycles",
				level, WAIT_LIMIT));
	endtask

	task automatic wait_finish();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (o_finish !== 1'b1 && n < WAIT_LIMIT);
		if (o_finish !== 1'b1)
			abort_run($sformatf("o_finish did not rise within %0d cycles", WAIT_LIMIT));
	endtask

	initial begin
		rst           = 1'b0;
		i_ctrl        = NOP;
		i_row         = '0;
		i_row_valid   = 1'b0;
		i_pad_row     = 1'b0;
		i_wbeat       = '0;
		i_wbeat_valid = 1'b0;
		test_name     = "reset";
		void'($urandom(80427));
		repeat (10) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		assert (o_products === '0 && !o_res_valid && !o_finish) else
			abort_run($sformatf("Error %s: outputs expected 0, actual %h %b %b",
				test_name, o_products, o_res_valid, o_finish));

		test_name = "plain window";
		send_beat({$urandom, $urandom});
		send_beat({$urandom, $urandom});
		repeat (KERNEL_DIM) push_row(rand_row(), 1'b0);
		command(START);
		wait_valid(1'b1);
		repeat (8) push_row(rand_row(), 1'b0);
		idle(3);

		test_name = "wrap-around";
		for (int r = 0; r < KERNEL_DIM; r++)
			push_row(distinct_row(r), 1'b0);
		idle(3);
		@(negedge clk);
		check_lane(6, 2, 0, 0); // Column 2 of cube 6 wraps to pixel 0
		check_lane(7, 1, 0, 0);
		check_lane(7, 2, 1, 0);
		check_lane(7, 8, 1, 2);

		test_name = "padding";
		pad_only();
		pad_only();
		idle(3);
		@(negedge clk);
		for (int k = 0; k < PIXELS; k++)
			assert (o_products[k*CUBE_W + KERNEL_DIM*PIX_W +: 2*KERNEL_DIM*PIX_W] === '0) else
				abort_run($sformatf("Error %s: cube %0d padded lanes expected 0, actual %h",
					test_name, k, o_products[k*CUBE_W +: CUBE_W]));
		push_row(rand_row(), 1'b1);
		idle(3);

		test_name = "hold";
		command(HOLD);
		command(NOP);
		wait_valid(1'b0);
		send_beat({$urandom, $urandom});
		@(posedge clk);
		i_ctrl        <= HOLD; // Beat lands at count 1 and then the count clears
		i_wbeat       <= {$urandom, $urandom};
		i_wbeat_valid <= 1'b1;
		command(NOP);
		send_beat({$urandom, $urandom});
		send_beat({$urandom, $urandom});
		send_beat({$urandom, $urandom}); // Third beat is dropped
		command(START);
		wait_valid(1'b1);
		repeat (4) push_row(rand_row(), 1'b0);
		idle(3);

		test_name = "end";
		command(END);
		wait_finish();
		command(START);
		command(HOLD);
		command(NOP);
		idle(4);

		if (UUT.u_checker.fail_cnt == 0) begin
			$display("Test passed");
			$finish;
		end else begin
			$display("Bound protocol assertions failed %0d times", UUT.u_checker.fail_cnt);
			$display("Test failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

/* compile.f */
logic/conv_pkg.sv
logic/row_window.sv
logic/kernel_bank.sv
logic/conv_sequencer.sv
logic/mult_cube.sv
logic/cube_array.sv
logic/conv_core.sv
tests/clk_gen.sv
tests/conv_checker.sv
tests/conv_tb.sv

/* Bender.yml */
package:
  name: conv_core

sources:
  - logic/conv_pkg.sv
  - logic/row_window.sv
  - logic/kernel_bank.sv
  - logic/conv_sequencer.sv
  - logic/mult_cube.sv
  - logic/cube_array.sv
  - logic/conv_core.sv
  - target: test
    files:
      - tests/clk_gen.sv
      - tests/conv_checker.sv
      - tests/conv_tb.sv
